//--- hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

  localparam int xlen = 32;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Opcodes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [3:0] {
    kind_alu,
    kind_lui,
    kind_auipc,
    kind_jal,
    kind_jalr,
    kind_mul,
    kind_div,
    kind_load,
    kind_store,
    kind_nop
  } exec_kind_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  typedef enum logic [1:0] {
    mul_mul,
    mul_mulh,
    mul_mulhsu,
    mul_mulhu
  } mul_op_e;

  typedef enum logic [1:0] {
    div_div,
    div_divu,
    div_rem,
    div_remu
  } div_op_e;

  typedef enum logic [2:0] {
    lsu_lb,
    lsu_lbu,
    lsu_lh,
    lsu_lhu,
    lsu_lw,
    lsu_sb,
    lsu_sh,
    lsu_sw
  } lsu_op_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage structs.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic            valid;
    exec_kind_e      kind;
    alu_op_e         alu_op;
    mul_op_e         mul_op;
    div_op_e         div_op;
    lsu_op_e         lsu_op;
    logic            sel_imm;
    logic [4:0]      waddr;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] pc;
  } issue_t;

  typedef struct packed {
    logic            wren;
    logic [4:0]      waddr;
    logic [xlen-1:0] wdata;
  } writeback_t;

  typedef struct packed {
    logic            valid;
    logic            write;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      byteenable;
  } mem_req_t;

  typedef struct packed {
    logic            ready;
    logic [xlen-1:0] rdata;
  } mem_rsp_t;

  // Empty slot in the instruction register.
  localparam issue_t issue_bubble = '{
    valid:   1'b0,
    kind:    kind_nop,
    alu_op:  alu_add,
    mul_op:  mul_mul,
    div_op:  div_div,
    lsu_op:  lsu_lb,
    sel_imm: 1'b0,
    waddr:   5'd0,
    rdata1:  '0,
    rdata2:  '0,
    imm:     '0,
    pc:      '0
  };

endpackage

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu
  import exec_pkg::*;
(
  input  alu_op_e         op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result
);

  logic [4:0] shamt;
  logic       less_signed;
  logic       less_unsigned;

  assign shamt         = b[4:0];
  assign less_signed   = $signed(a) < $signed(b);
  assign less_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, less_signed};
      alu_sltu: result = {{(xlen-1){1'b0}}, less_unsigned};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      // Arithmetic shift keeps the sign bit.
      alu_sra:  result = $signed(a) >>> shamt;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/multiplier.sv
`timescale 1ns/100ps
`default_nettype none

module multiplier
  import exec_pkg::*;
(
  input  mul_op_e         op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result
);

  logic               a_signed;
  logic               b_signed;
  logic signed [xlen:0]     a_ext;
  logic signed [xlen:0]     b_ext;
  logic signed [2*xlen+1:0] product;

  // Low word does not depend on signedness.
  assign a_signed = (op == mul_mulh) || (op == mul_mulhsu);
  assign b_signed = (op == mul_mulh);

  assign a_ext   = {a_signed & a[xlen-1], a};
  assign b_ext   = {b_signed & b[xlen-1], b};
  assign product = a_ext * b_ext;

  assign result = (op == mul_mul) ? product[xlen-1:0] : product[2*xlen-1:xlen];

endmodule

`default_nettype wire

//--- hw/divider.sv
`timescale 1ns/100ps
`default_nettype none

module divider
  import exec_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            start,
  input  div_op_e         op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic            done,
  output logic [xlen-1:0] result
);

  typedef enum logic [1:0] {
    div_idle,
    div_run,
    div_fix
  } div_state_e;

  div_state_e      state;
  logic [4:0]      count;
  logic [xlen-1:0] rem;
  logic [xlen-1:0] quo;
  logic [xlen-1:0] divisor;
  logic            neg_q;
  logic            neg_r;
  logic            want_rem;

  logic            is_signed;
  logic            a_neg;
  logic            b_neg;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;
  logic [xlen:0]   shifted;
  logic [xlen:0]   diff;

  always_comb begin
    is_signed = (op == div_div) || (op == div_rem);
    a_neg     = is_signed & a[xlen-1];
    b_neg     = is_signed & b[xlen-1];
    a_mag     = a_neg ? -a : a;
    b_mag     = b_neg ? -b : b;
    // One restoring step.
    shifted   = {rem, quo[xlen-1]};
    diff      = shifted - {1'b0, divisor};
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state <= div_idle;
      count <= '0;
    end else begin
      case (state)
        div_idle: begin
          count <= '0;
          if (start) begin
            state <= div_run;
          end
        end
        div_run: begin
          count <= count + 5'd1;
          if (!start) begin
            state <= div_idle;
          end else if (count == 5'd31) begin
            state <= div_fix;
          end
        end
        default: state <= div_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == div_idle) begin
      rem      <= '0;
      quo      <= a_mag;
      divisor  <= b_mag;
      // Zero divisor keeps the all-ones quotient.
      neg_q    <= (a_neg ^ b_neg) && (b != '0);
      neg_r    <= a_neg;
      want_rem <= (op == div_rem) || (op == div_remu);
    end else if (state == div_run) begin
      if (!diff[xlen]) begin
        rem <= diff[xlen-1:0];
        quo <= {quo[xlen-2:0], 1'b1};
      end else begin
        rem <= shifted[xlen-1:0];
        quo <= {quo[xlen-2:0], 1'b0};
      end
    end
  end

  // Sign fix in the final cycle.
  always_comb begin
    if (want_rem) begin
      result = neg_r ? -rem : rem;
    end else begin
      result = neg_q ? -quo : quo;
    end
  end

  assign done = (state == div_fix);

endmodule

`default_nettype wire

//--- hw/lsu.sv
`timescale 1ns/100ps
`default_nettype none

module lsu
  import exec_pkg::*;
(
  input  lsu_op_e         op,
  input  logic [1:0]      offset,
  input  logic [xlen-1:0] store_data,
  input  logic [xlen-1:0] load_word,
  output logic [3:0]      byteenable,
  output logic [xlen-1:0] wdata,
  output logic [xlen-1:0] load_data
);

  logic [7:0]  load_byte;
  logic [15:0] load_half;

  assign load_byte = load_word[8*offset +: 8];
  assign load_half = offset[1] ? load_word[31:16] : load_word[15:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lane placement, by access size.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (op)
      lsu_lb, lsu_lbu, lsu_sb: begin
        byteenable = 4'b0001 << offset;
        wdata      = {4{store_data[7:0]}};
      end
      lsu_lh, lsu_lhu, lsu_sh: begin
        byteenable = offset[1] ? 4'b1100 : 4'b0011;
        wdata      = {2{store_data[15:0]}};
      end
      default: begin
        byteenable = 4'b1111;
        wdata      = store_data;
      end
    endcase
  end

  always_comb begin
    case (op)
      lsu_lb:  load_data = {{24{load_byte[7]}}, load_byte};
      lsu_lbu: load_data = {24'd0, load_byte};
      lsu_lh:  load_data = {{16{load_half[15]}}, load_half};
      lsu_lhu: load_data = {16'd0, load_half};
      default: load_data = load_word;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage
  import exec_pkg::*;
(
  input  logic            clock,
  input  logic            reset,
  input  logic            clear,
  input  issue_t          issue,
  output logic            stall,
  output writeback_t      wb,
  output mem_req_t        mem_req,
  input  mem_rsp_t        mem_rsp,
  output alu_op_e         alu_op,
  output logic [xlen-1:0] alu_a,
  output logic [xlen-1:0] alu_b,
  input  logic [xlen-1:0] alu_result,
  output mul_op_e         mul_op,
  input  logic [xlen-1:0] mul_result,
  output logic            div_start,
  output div_op_e         div_op,
  input  logic            div_done,
  input  logic [xlen-1:0] div_result,
  output lsu_op_e         lsu_op,
  output logic [1:0]      lsu_offset,
  input  logic [3:0]      lsu_byteenable,
  input  logic [xlen-1:0] lsu_wdata,
  input  logic [xlen-1:0] lsu_load_data
);

  issue_t          r;
  logic [xlen-1:0] eff_addr;
  logic            is_mem;
  logic            writes;
  logic [xlen-1:0] wdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      r <= issue_bubble;
    end else if (clear) begin
      r <= issue_bubble;
    end else if (!stall) begin
      r <= issue.valid ? issue : issue_bubble;
    end
  end

  assign eff_addr = r.rdata1 + r.imm;
  assign is_mem   = (r.kind == kind_load) || (r.kind == kind_store);
  assign writes   = r.valid && (r.kind != kind_store) && (r.kind != kind_nop);

  // Second operand is rdata2 for everything but immediate ALU ops.
  assign alu_op = r.alu_op;
  assign alu_a  = r.rdata1;
  assign alu_b  = (r.kind == kind_alu && r.sel_imm) ? r.imm : r.rdata2;

  assign mul_op    = r.mul_op;
  assign div_op    = r.div_op;
  assign div_start = (r.kind == kind_div) & ~clear;

  assign lsu_op     = r.lsu_op;
  assign lsu_offset = eff_addr[1:0];

  always_comb begin
    case (r.kind)
      kind_div:               stall = ~div_done;
      kind_load, kind_store:  stall = ~mem_rsp.ready;
      default:                stall = 1'b0;
    endcase
  end

  always_comb begin
    case (r.kind)
      kind_lui:            wdata = r.imm;
      kind_auipc:          wdata = r.pc + r.imm;
      kind_jal, kind_jalr: wdata = r.pc + 32'd4;
      kind_mul:            wdata = mul_result;
      kind_div:            wdata = div_result;
      kind_load:           wdata = lsu_load_data;
      default:             wdata = alu_result;
    endcase
  end

  // No write for x0, while stalled, or when flushed.
  assign wb.wren  = writes && !stall && !clear && (r.waddr != 5'd0);
  assign wb.waddr = r.waddr;
  assign wb.wdata = wdata;

  assign mem_req.valid      = is_mem;
  assign mem_req.write      = (r.kind == kind_store);
  assign mem_req.addr       = eff_addr;
  assign mem_req.wdata      = lsu_wdata;
  assign mem_req.byteenable = lsu_byteenable;

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit
  import exec_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       clear,
  input  issue_t     issue,
  output logic       stall,
  output writeback_t wb,
  output mem_req_t   mem_req,
  input  mem_rsp_t   mem_rsp
);

  alu_op_e         alu_op;
  logic [xlen-1:0] operand_a;
  logic [xlen-1:0] operand_b;
  logic [xlen-1:0] alu_result;
  mul_op_e         mul_op;
  logic [xlen-1:0] mul_result;
  logic            div_start;
  div_op_e         div_op;
  logic            div_done;
  logic [xlen-1:0] div_result;
  lsu_op_e         lsu_op;
  logic [1:0]      lsu_offset;
  logic [3:0]      lsu_byteenable;
  logic [xlen-1:0] lsu_wdata;
  logic [xlen-1:0] lsu_load_data;

  execute_stage u_stage (
    .clock          (clock),
    .reset          (reset),
    .clear          (clear),
    .issue          (issue),
    .stall          (stall),
    .wb             (wb),
    .mem_req        (mem_req),
    .mem_rsp        (mem_rsp),
    .alu_op         (alu_op),
    .alu_a          (operand_a),
    .alu_b          (operand_b),
    .alu_result     (alu_result),
    .mul_op         (mul_op),
    .mul_result     (mul_result),
    .div_start      (div_start),
    .div_op         (div_op),
    .div_done       (div_done),
    .div_result     (div_result),
    .lsu_op         (lsu_op),
    .lsu_offset     (lsu_offset),
    .lsu_byteenable (lsu_byteenable),
    .lsu_wdata      (lsu_wdata),
    .lsu_load_data  (lsu_load_data)
  );

  alu u_alu (
    .op     (alu_op),
    .a      (operand_a),
    .b      (operand_b),
    .result (alu_result)
  );

  multiplier u_mul (
    .op     (mul_op),
    .a      (operand_a),
    .b      (operand_b),
    .result (mul_result)
  );

  divider u_div (
    .clock  (clock),
    .reset  (reset),
    .start  (div_start),
    .op     (div_op),
    .a      (operand_a),
    .b      (operand_b),
    .done   (div_done),
    .result (div_result)
  );

  // Store data is the resident rdata2.
  lsu u_lsu (
    .op         (lsu_op),
    .offset     (lsu_offset),
    .store_data (operand_b),
    .load_word  (mem_rsp.rdata),
    .byteenable (lsu_byteenable),
    .wdata      (lsu_wdata),
    .load_data  (lsu_load_data)
  );

endmodule

`default_nettype wire

//--- verification/tb_execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_execute_unit
  import exec_pkg::*;
();

  localparam int n_alu   = 40;
  localparam int n_mul   = 24;
  localparam int n_div   = 16;
  localparam int n_pairs = 24;
  localparam int total_instr = n_alu + n_mul + n_div + 2 * n_pairs + 4;
  localparam int cycle_limit = 60 * total_instr + 20;

  logic       clock;
  logic       reset;
  logic       clear;
  issue_t     issue;
  logic       stall;
  writeback_t wb;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;

  logic [31:0] mem [256];
  logic [31:0] model_mem [256];
  writeback_t  exp_q [$];
  int          due_q [$];
  logic [3:0]  be_q [$];
  logic        pending;
  logic [31:0] wait_left;
  int          cycles;
  int          checks;
  int          errors;
  int          prev_checks;
  int          prev_errors;

  execute_unit dut (
    .clock   (clock),
    .reset   (reset),
    .clear   (clear),
    .issue   (issue),
    .stall   (stall),
    .wb      (wb),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  always #5 clock = ~clock;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [3:0] lane_mask(input lsu_op_e op, input logic [1:0] offs);
    case (op)
      lsu_lb, lsu_lbu, lsu_sb: return 4'b0001 << offs;
      lsu_lh, lsu_lhu, lsu_sh: return offs[1] ? 4'b1100 : 4'b0011;
      default:                 return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] div_ref(input div_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic        overflow;
    logic [31:0] res;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      div_div: begin
        if (b == 0) begin
          res = 32'hffff_ffff;
        end else if (overflow) begin
          res = a;
        end else begin
          res = $signed(a) / $signed(b);
        end
      end
      div_divu: res = (b == 0) ? 32'hffff_ffff : a / b;
      div_rem: begin
        if (b == 0) begin
          res = a;
        end else if (overflow) begin
          res = 32'd0;
        end else begin
          res = $signed(a) % $signed(b);
        end
      end
      default: res = (b == 0) ? a : a % b;
    endcase
    return res;
  endfunction

  function automatic writeback_t exec_model(input issue_t ins, output logic [3:0] be);
    writeback_t  w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] data;
    logic [63:0] p;
    logic [7:0]  idx;
    logic [7:0]  byte_v;
    logic [15:0] half_v;
    a       = ins.rdata1;
    b       = (ins.kind == kind_alu && ins.sel_imm) ? ins.imm : ins.rdata2;
    addr    = ins.rdata1 + ins.imm;
    idx     = addr[9:2];
    word    = model_mem[idx];
    be      = lane_mask(ins.lsu_op, addr[1:0]);
    w.wren  = ins.valid && ins.kind != kind_store && ins.kind != kind_nop && ins.waddr != 0;
    w.waddr = ins.waddr;
    w.wdata = '0;
    case (ins.kind)
      kind_alu: begin
        case (ins.alu_op)
          alu_add:  w.wdata = a + b;
          alu_sub:  w.wdata = a - b;
          alu_sll:  w.wdata = a << b[4:0];
          alu_slt:  w.wdata = {31'd0, $signed(a) < $signed(b)};
          alu_sltu: w.wdata = {31'd0, a < b};
          alu_xor:  w.wdata = a ^ b;
          alu_srl:  w.wdata = a >> b[4:0];
          alu_sra:  w.wdata = $signed(a) >>> b[4:0];
          alu_or:   w.wdata = a | b;
          default:  w.wdata = a & b;
        endcase
      end
      kind_lui:   w.wdata = ins.imm;
      kind_auipc: w.wdata = ins.pc + ins.imm;
      kind_jal, kind_jalr: w.wdata = ins.pc + 32'd4;
      kind_mul: begin
        case (ins.mul_op)
          mul_mul, mul_mulh: p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
          mul_mulhsu:        p = {{32{a[31]}}, a} * {32'd0, b};
          default:           p = {32'd0, a} * {32'd0, b};
        endcase
        w.wdata = (ins.mul_op == mul_mul) ? p[31:0] : p[63:32];
      end
      kind_div: w.wdata = div_ref(ins.div_op, a, ins.rdata2);
      kind_store: begin
        data = (ins.lsu_op == lsu_sb) ? {4{ins.rdata2[7:0]}} :
               (ins.lsu_op == lsu_sh) ? {2{ins.rdata2[15:0]}} : ins.rdata2;
        for (int k = 0; k < 4; k++) begin
          if (be[k]) model_mem[idx][8*k +: 8] = data[8*k +: 8];
        end
      end
      kind_load: begin
        byte_v = word[8*addr[1:0] +: 8];
        half_v = addr[1] ? word[31:16] : word[15:0];
        case (ins.lsu_op)
          lsu_lb:  w.wdata = {{24{byte_v[7]}}, byte_v};
          lsu_lbu: w.wdata = {24'd0, byte_v};
          lsu_lh:  w.wdata = {{16{half_v[15]}}, half_v};
          lsu_lhu: w.wdata = {16'd0, half_v};
          default: w.wdata = word;
        endcase
      end
      default: w.wdata = '0;
    endcase
    return w;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = $urandom;
    case (r[2:0])
      3'd0:    return 32'd0;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return 32'h8000_0000;
      default: return $urandom;
    endcase
  endfunction

  function automatic issue_t random_ins(input exec_kind_e kind);
    issue_t      ins;
    logic [31:0] r;
    r           = $urandom;
    ins         = issue_bubble;
    ins.valid   = 1'b1;
    ins.kind    = kind;
    ins.waddr   = r[4:0];
    ins.sel_imm = r[5];
    ins.rdata1  = pick_operand();
    ins.rdata2  = pick_operand();
    ins.imm     = $urandom;
    ins.pc      = $urandom & 32'hffff_fffc;
    return ins;
  endfunction

  // Called at a rising edge; returns at the accepting edge.
  task automatic issue_one(input issue_t ins);
    writeback_t w;
    logic [3:0] be;
    int         due;
    issue <= ins;
    do @(negedge clock); while (stall);
    // Completion cycle, zero where memory latency decides it.
    if (ins.kind == kind_load || ins.kind == kind_store) begin
      due = 0;
    end else if (ins.kind == kind_div) begin
      due = cycles + 34;
    end else begin
      due = cycles + 1;
    end
    @(posedge clock);
    w = exec_model(ins, be);
    if (w.wren) begin
      exp_q.push_back(w);
      due_q.push_back(due);
    end
    if (ins.kind == kind_load || ins.kind == kind_store) be_q.push_back(be);
  endtask

  task automatic flush_one(input issue_t ins, input int hold);
    issue <= ins;
    do @(negedge clock); while (stall);
    @(posedge clock);
    issue <= issue_bubble;
    repeat (hold) @(posedge clock);
    clear <= 1'b1;
    @(posedge clock);
    clear <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    issue <= issue_bubble;
    do @(negedge clock); while (exp_q.size() != 0 || stall);
    @(posedge clock);
    $display("%s: %0d checks, %0d errors", name, checks - prev_checks, errors - prev_errors);
    prev_checks = checks;
    prev_errors = errors;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory, comparison and timeout.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clock) begin
    if (!reset || clear || mem_rsp.ready) begin
      mem_rsp.ready <= 1'b0;
      pending       <= 1'b0;
    end else if (mem_req.valid) begin
      if (!pending) begin
        pending   <= 1'b1;
        wait_left <= $urandom_range(0, 4);
      end else if (wait_left != 0) begin
        wait_left <= wait_left - 1;
      end else begin
        mem_rsp.ready <= 1'b1;
        mem_rsp.rdata <= mem[mem_req.addr[9:2]];
        if (mem_req.write) begin
          for (int k = 0; k < 4; k++) begin
            if (mem_req.byteenable[k]) begin
              mem[mem_req.addr[9:2]][8*k +: 8] <= mem_req.wdata[8*k +: 8];
            end
          end
        end
        checks++;
        if (be_q.size() == 0) begin
          $display("memory request at %0t with no expected access", $time);
          errors++;
        end else if (mem_req.byteenable != be_q[0]) begin
          $display("error at %0t: mem_req.byteenable got %h expected %h",
                   $time, mem_req.byteenable, be_q[0]);
          errors++;
        end
        if (be_q.size() != 0) void'(be_q.pop_front());
      end
    end
  end

  always @(negedge clock) begin
    writeback_t e;
    int         due;
    if (reset && wb.wren) begin
      checks++;
      if (exp_q.size() == 0) begin
        $display("unexpected register write to x%0d at %0t", wb.waddr, $time);
        errors++;
      end else begin
        e   = exp_q.pop_front();
        due = due_q.pop_front();
        if (due != 0 && cycles != due) begin
          $display("error at %0t: wb.wren cycle got %0d expected %0d", $time, cycles, due);
          errors++;
        end
        if (wb.waddr != e.waddr) begin
          $display("error at %0t: wb.waddr got %0d expected %0d", $time, wb.waddr, e.waddr);
          errors++;
        end
        if (wb.wdata != e.wdata) begin
          $display("error at %0t: wb.wdata got %h expected %h", $time, wb.wdata, e.wdata);
          errors++;
        end
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    issue_t      ins;
    logic [31:0] r;
    logic [31:0] addr;
    void'($urandom(32'h98af));
    clock   = 1'b0;
    reset   = 1'b0;
    clear   = 1'b0;
    issue   = issue_bubble;
    mem_rsp = '0;
    pending = 1'b0;
    wait_left = '0;
    cycles = 0;
    checks = 0;
    errors = 0;
    prev_checks = 0;
    prev_errors = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i]       = (i * 32'h9e37_79b1) ^ {i[7:0], ~i[7:0], i[7:0], 8'h5a};
      model_mem[i] = mem[i];
    end
    repeat (5) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    checks++;
    if (stall || wb.wren || mem_req.valid) begin
      $display("outputs not idle after reset at %0t", $time);
      errors++;
    end
    @(posedge clock);
    finish_test("reset");

    for (int i = 0; i < n_alu; i++) begin
      r   = $urandom_range(0, 4);
      ins = random_ins(exec_kind_e'(r[3:0]));
      r   = $urandom_range(0, 9);
      ins.alu_op = alu_op_e'(r[3:0]);
      if (i % 8 == 0) ins.waddr = 5'd0;
      issue_one(ins);
    end
    finish_test("alu");

    for (int i = 0; i < n_mul; i++) begin
      ins = random_ins(kind_mul);
      ins.mul_op = mul_op_e'(i[1:0]);
      issue_one(ins);
    end
    finish_test("mul");

    for (int i = 0; i < n_div; i++) begin
      ins = random_ins(kind_div);
      ins.div_op = div_op_e'(i[1:0]);
      if (i < 4) begin
        ins.rdata2 = 32'd0;
      end else if (i < 8) begin
        ins.rdata1 = 32'h8000_0000;
        ins.rdata2 = 32'hffff_ffff;
      end
      issue_one(ins);
    end
    finish_test("div");

    for (int i = 0; i < n_pairs; i++) begin
      r    = $urandom_range(0, 2);
      addr = {22'd0, 8'($urandom_range(0, 255)), 2'b00};
      ins  = random_ins(kind_store);
      ins.lsu_op = lsu_op_e'(3'd5 + r[2:0]);
      if (r == 0) addr[1:0] = 2'($urandom_range(0, 3));
      if (r == 1) addr[1] = r[0] ^ addr[2];
      ins.imm    = $urandom_range(0, 63) - 32'd32;
      ins.rdata1 = addr - ins.imm;
      issue_one(ins);
      ins = random_ins(kind_load);
      r   = addr[0] ? $urandom_range(0, 1) : addr[1] ? $urandom_range(0, 3) :
            $urandom_range(0, 4);
      ins.lsu_op = lsu_op_e'(r[2:0]);
      ins.imm    = $urandom_range(0, 63) - 32'd32;
      ins.rdata1 = addr - ins.imm;
      issue_one(ins);
    end
    finish_test("load/store");

    // Flushed division, then a flushed load, each followed by a normal op.
    ins = random_ins(kind_div);
    ins.waddr = 5'd7;
    flush_one(ins, 5);
    ins = random_ins(kind_alu);
    issue_one(ins);
    ins = random_ins(kind_load);
    ins.lsu_op = lsu_lw;
    ins.waddr  = 5'd9;
    ins.imm    = 32'd0;
    ins.rdata1 = 32'h40;
    flush_one(ins, 0);
    ins = random_ins(kind_lui);
    issue_one(ins);
    finish_test("clear");

    $display("total: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
hw/exec_pkg.sv
hw/alu.sv
hw/multiplier.sv
hw/divider.sv
hw/lsu.sv
hw/execute_stage.sv
hw/execute_unit.sv
verification/tb_execute_unit.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_execute_unit -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
